// ==== dv/gpio_tb.sv ====
`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_tb;

   // ##############################
   // Test sizes and run limit
   // ##############################
   localparam int N_OUT_OPS   = 40;
   localparam int N_IN_OPS    = 6;
   localparam int N_IRQ_OPS   = 8;
   localparam int N_BP_READS  = 20;
   localparam int HOLD_CYCLES = 20;    // Input settle time
   localparam int MAX_STALL   = 16;
   // Reads, writes and input steps over all tests
   localparam int N_TXN = 8 + 2*N_OUT_OPS + 2*N_IN_OPS + 4 + 4*N_IRQ_OPS + 4 + N_BP_READS;
   localparam int TXN_CYC = HOLD_CYCLES + MAX_STALL + 10;   // Worst case per transaction
   localparam int TIMEOUT_CYCLES = N_TXN * TXN_CYC + 20;

   logic               clk;
   logic               reset;
   logic               access_in;
   gpio_pkg::packet_t  packet_in;
   logic               wait_out;
   logic               access_out;
   gpio_pkg::packet_t  packet_out;
   logic               wait_in;
   gpio_pkg::pin_vec_t gpio_in;
   gpio_pkg::pin_vec_t gpio_out;
   gpio_pkg::pin_vec_t gpio_oen;
   logic               gpio_irq;

   // Register model
   gpio_pkg::pin_vec_t m_out;
   gpio_pkg::pin_vec_t m_oen;
   gpio_pkg::pin_vec_t m_ie;
   gpio_pkg::pin_vec_t m_ipol;
   gpio_pkg::pin_vec_t m_ilat;
   gpio_pkg::pin_vec_t m_in;       // Settled pin value

   gpio_pkg::packet_t exp_q[$];    // Expected responses, request order
   logic [31:0]       rng_state;
   int                errors = 0;
   int                checks = 0;
   int                tests  = 0;

   // Monitor side
   int                rd_idx     = 0;   // Next expected entry
   int                mon_errors = 0;
   int                mon_checks = 0;
   gpio_pkg::packet_t held_pkt   = '0;
   logic              held_valid = 1'b0;
   int                cycle_cnt  = 0;

   gpio_top uut (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .gpio_in    (gpio_in),
      .gpio_out   (gpio_out),
      .gpio_oen   (gpio_oen),
      .gpio_irq   (gpio_irq)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 100 MHz
   end

   // ##############################
   // Random source and model
   // ##############################
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function logic [31:0] rand_word();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Latch sets where the active level goes 0 to 1
   function automatic gpio_pkg::pin_vec_t latch_rule(input gpio_pkg::pin_vec_t ilat,
         input gpio_pkg::pin_vec_t old_lvl, input gpio_pkg::pin_vec_t new_lvl);
      return ilat | (new_lvl & ~old_lvl);
   endfunction

   // Expected read value per register index
   function gpio_pkg::word_t ref_read(input gpio_pkg::reg_addr_t idx);
      case (idx)
         `GPIO_REG_OUT, `GPIO_REG_OUTSET, `GPIO_REG_OUTCLR: return m_out;
         `GPIO_REG_OEN:  return m_oen;
         `GPIO_REG_IN:   return m_in;
         `GPIO_REG_IE:   return m_ie;
         `GPIO_REG_IPOL: return m_ipol;
         `GPIO_REG_ILAT: return m_ilat;
         default:        return '0;
      endcase
   endfunction

   function void model_write(input gpio_pkg::reg_addr_t idx, input gpio_pkg::word_t d);
      case (idx)
         `GPIO_REG_OUT:    m_out = d;
         `GPIO_REG_OEN:    m_oen = d;
         `GPIO_REG_IE:     m_ie  = d;
         `GPIO_REG_IPOL: begin
            m_ilat = latch_rule(m_ilat, m_in ^ m_ipol, m_in ^ d);  // Polarity flip is an edge
            m_ipol = d;
         end
         `GPIO_REG_ILAT:   m_ilat = m_ilat & ~d;     // Write 1 clears
         `GPIO_REG_OUTSET: m_out  = m_out | d;
         `GPIO_REG_OUTCLR: m_out  = m_out & ~d;
         default: ;
      endcase
   endfunction

   function automatic gpio_pkg::packet_t make_req(input logic wr, input gpio_pkg::word_t dst,
         input gpio_pkg::word_t data, input gpio_pkg::word_t src);
      gpio_pkg::packet_t p;
      p = '0;
      p[`GPIO_PKT_WRITE]    = wr;
      p[`GPIO_PKT_DATAMODE] = src[1:0];     // Don't care for the DUT
      p[`GPIO_PKT_CTRLMODE] = src[6:2];
      p[`GPIO_PKT_DSTADDR]  = dst;
      p[`GPIO_PKT_DATA]     = data;
      p[`GPIO_PKT_SRCADDR]  = src;
      return p;
   endfunction

   // Response goes back to the requester, addresses swapped
   function automatic gpio_pkg::packet_t make_resp(input gpio_pkg::word_t src,
         input gpio_pkg::word_t dst, input gpio_pkg::word_t data);
      gpio_pkg::packet_t p;
      p = '0;
      p[`GPIO_PKT_DATAMODE] = 2'd2;
      p[`GPIO_PKT_DSTADDR]  = src;
      p[`GPIO_PKT_DATA]     = data;
      p[`GPIO_PKT_SRCADDR]  = dst;
      return p;
   endfunction

   // ##############################
   // Driver tasks
   // ##############################
   task automatic report_fail(input string msg);
      errors++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   task automatic check_word(input string what, input gpio_pkg::word_t got,
         input gpio_pkg::word_t exp);
      checks++;
      if (got !== exp) begin
         report_fail($sformatf("%s got %h expected %h", what, got, exp));
      end
   endtask

   task automatic check_pins();
      check_word("gpio_out", gpio_out, m_out);
      check_word("gpio_oen", gpio_oen, m_oen);
      checks++;
      if (gpio_irq !== |(m_ilat & m_ie)) begin
         report_fail($sformatf("gpio_irq got %b expected %b", gpio_irq, |(m_ilat & m_ie)));
      end
   endtask

   // One-cycle request, only while the DUT is idle
   task automatic send_req(input gpio_pkg::packet_t pkt);
      @(negedge clk);
      while (wait_out) @(negedge clk);
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= pkt;
      @(posedge clk);             // Accept edge
      access_in <= 1'b0;
   endtask

   task automatic wait_idle();
      @(negedge clk);
      while (wait_out) @(negedge clk);
   endtask

   task automatic write_reg(input gpio_pkg::reg_addr_t idx, input gpio_pkg::word_t data);
      gpio_pkg::word_t dst;
      dst = rand_word();
      dst = {dst[31:6], idx, 2'b00};
      model_write(idx, data);
      send_req(make_req(1'b1, dst, data, rand_word()));
      wait_idle();
      check_word("gpio_out", gpio_out, m_out);   // Right after the write edge
      check_word("gpio_oen", gpio_oen, m_oen);
      @(negedge clk);              // Latch from an IPOL write shows one edge later
      check_pins();
   endtask

   // stall > 0 holds wait_in high that many cycles after accept
   task automatic read_reg(input gpio_pkg::reg_addr_t idx, input int stall);
      gpio_pkg::word_t dst;
      gpio_pkg::word_t src;
      dst = rand_word();
      dst = {dst[31:6], idx, 2'b00};
      src = rand_word();
      exp_q.push_back(make_resp(src, dst, ref_read(idx)));
      if (stall > 0) begin
         @(posedge clk);
         wait_in <= 1'b1;
      end
      send_req(make_req(1'b0, dst, rand_word(), src));
      if (stall > 0) begin
         repeat (stall) @(posedge clk);
         wait_in <= 1'b0;
      end
      wait_idle();
   endtask

   task automatic apply_inputs(input gpio_pkg::pin_vec_t v);
      @(posedge clk);
      gpio_in <= v;
      repeat (HOLD_CYCLES) @(posedge clk);
      m_ilat = latch_rule(m_ilat, m_in ^ m_ipol, v ^ m_ipol);
      m_in   = v;
      @(negedge clk);
      check_pins();
   endtask

   // Pulse shorter than the debounce window, then back
   task automatic glitch_inputs(input gpio_pkg::pin_vec_t v);
      @(posedge clk);
      gpio_in <= v;
      repeat (`GPIO_DEBOUNCE_CYCLES - 1) @(posedge clk);
      gpio_in <= m_in;
      repeat (HOLD_CYCLES) @(posedge clk);
   endtask

   task automatic end_test(input string name, input int err_start);
      int n;
      n = errors + mon_errors - err_start;
      tests++;
      $display("test %s: %s, %0d errors", name, (n == 0) ? "ok" : "failed", n);
   endtask

   // ##############################
   // Response monitor
   // ##############################
   always @(negedge clk) begin
      if (!reset && access_out) begin
         if (held_valid && packet_out !== held_pkt) begin
            mon_errors++;
            $display("[FAIL] %0t: packet_out changed under wait_in", $time);
         end
         if (!wait_out) begin
            mon_errors++;
            $display("[FAIL] %0t: wait_out low with a response pending", $time);
         end
         held_pkt   = packet_out;
         held_valid = 1'b1;
         if (!wait_in) begin        // Taken on the next edge
            held_valid = 1'b0;
            if (rd_idx >= exp_q.size()) begin
               mon_errors++;
               $display("Unexpected response at %0t with no read outstanding", $time);
            end else begin
               mon_checks++;
               if (packet_out !== exp_q[rd_idx]) begin
                  mon_errors++;
                  $display("[FAIL] %0t: response got %h expected %h", $time,
                           packet_out, exp_q[rd_idx]);
               end
               rd_idx++;
            end
         end
      end
   end

   // Watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // ##############################
   // Test sequence
   // ##############################
   initial begin
      int              err_start;
      int              total_err;
      gpio_pkg::word_t r;
      gpio_pkg::reg_addr_t idx;
      reset     <= 1'b1;
      access_in <= 1'b0;
      packet_in <= '0;
      wait_in   <= 1'b0;
      gpio_in   <= '0;
      rng_state = 32'd72073;
      m_out = '0;
      m_oen = '0;
      m_ie = '0;
      m_ipol = '0;
      m_ilat = '0;
      m_in = '0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);

      // Reset state
      err_start = errors + mon_errors;
      checks++;
      if (access_out || wait_out || gpio_irq) begin
         report_fail("access_out, wait_out or gpio_irq high after reset");
      end
      for (int i = 0; i < 8; i++) begin
         read_reg(gpio_pkg::reg_addr_t'(i), 0);
      end
      end_test("reset_state", err_start);

      // Output registers
      err_start = errors + mon_errors;
      for (int i = 0; i < N_OUT_OPS; i++) begin
         r = rand_word();
         case (r[1:0])
            2'd0:    idx = `GPIO_REG_OUT;
            2'd1:    idx = `GPIO_REG_OEN;
            2'd2:    idx = `GPIO_REG_OUTSET;
            default: idx = `GPIO_REG_OUTCLR;
         endcase
         write_reg(idx, rand_word());
         read_reg(r[2] ? `GPIO_REG_OEN : `GPIO_REG_OUT, 0);
      end
      end_test("output_regs", err_start);

      // Debounced input
      err_start = errors + mon_errors;
      for (int i = 0; i < N_IN_OPS; i++) begin
         apply_inputs(rand_word());
         read_reg(`GPIO_REG_IN, 0);
      end
      write_reg(`GPIO_REG_ILAT, '1);   // Empty latch records any leaked edge
      glitch_inputs(~m_in);
      read_reg(`GPIO_REG_IN, 0);   // Still the settled value
      read_reg(`GPIO_REG_ILAT, 0);   // Glitch never reached the latch
      end_test("debounce", err_start);

      // Interrupt latch
      err_start = errors + mon_errors;
      write_reg(`GPIO_REG_IE, rand_word());
      write_reg(`GPIO_REG_IPOL, rand_word());
      read_reg(`GPIO_REG_ILAT, 0);
      for (int i = 0; i < N_IRQ_OPS; i++) begin
         apply_inputs(rand_word());
         read_reg(`GPIO_REG_ILAT, 0);
         write_reg(`GPIO_REG_ILAT, rand_word());
         read_reg(`GPIO_REG_ILAT, 0);
      end
      write_reg(`GPIO_REG_ILAT, '1);
      checks++;
      if (gpio_irq) begin
         report_fail("gpio_irq still high with every latch cleared");
      end
      end_test("interrupt", err_start);

      // Back-pressure on read responses
      err_start = errors + mon_errors;
      for (int i = 0; i < N_BP_READS; i++) begin
         r = rand_word();
         read_reg({1'b0, r[2:0]}, 1 + int'(r[11:8]));
      end
      end_test("backpressure", err_start);

      repeat (4) @(negedge clk);
      if (rd_idx != exp_q.size()) begin
         errors++;
         $display("Missing responses: %0d reads got no reply", exp_q.size() - rd_idx);
      end
      total_err = errors + mon_errors;
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks + mon_checks,
               total_err);
      if (total_err == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+hw
hw/gpio_pkg.sv
hw/gpio_access_fsm.sv
hw/gpio_regs.sv
hw/gpio_debounce.sv
hw/gpio_top.sv
dv/gpio_tb.sv

// ==== hw/gpio_access_fsm.sv ====
`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_access_fsm (
   input  logic                    clk,
   input  logic                    reset,
   // Mesh request side
   input  logic                    access_in,
   input  gpio_pkg::packet_t       packet_in,
   output logic                    wait_out,
   // Mesh response side
   output logic                    access_out,
   output gpio_pkg::packet_t       packet_out,
   input  logic                    wait_in,
   // Register bank
   output logic                    reg_wr,
   output gpio_pkg::reg_addr_t     reg_addr,
   output gpio_pkg::word_t         reg_wdata,
   input  gpio_pkg::word_t         reg_rdata
);

   gpio_pkg::access_state_t state;
   gpio_pkg::packet_t       req_pkt;   // Request taken at accept edge
   gpio_pkg::packet_t       resp_pkt;  // Response under construction

   logic                    req_write;
   gpio_pkg::word_t         req_dstaddr;
   gpio_pkg::word_t         req_data;
   gpio_pkg::word_t         req_srcaddr;
   logic                    accept;

   // ##############################
   // Request decode
   // ##############################

   assign req_write   = req_pkt[`GPIO_PKT_WRITE];
   assign req_dstaddr = req_pkt[`GPIO_PKT_DSTADDR];
   assign req_data    = req_pkt[`GPIO_PKT_DATA];
   assign req_srcaddr = req_pkt[`GPIO_PKT_SRCADDR];
   // datamode and ctrlmode ride along unused

   assign wait_out = (state != gpio_pkg::IDLE);  // Busy outside IDLE
   assign accept   = access_in && (state == gpio_pkg::IDLE);

   // Word index from the byte address
   assign reg_addr  = req_dstaddr[5:2];
   assign reg_wdata = req_data;
   assign reg_wr    = (state == gpio_pkg::EXEC) && req_write;  // One-cycle strobe

   // ##############################
   // Response packet
   // ##############################

   always_comb begin
      resp_pkt                       = '0;
      resp_pkt[`GPIO_PKT_WRITE]      = 1'b0;
      resp_pkt[`GPIO_PKT_DATAMODE]   = 2'd2;     // Word
      resp_pkt[`GPIO_PKT_CTRLMODE]   = 5'd0;
      resp_pkt[`GPIO_PKT_DSTADDR]    = req_srcaddr;  // Back to the sender
      resp_pkt[`GPIO_PKT_DATA]       = reg_rdata;
      resp_pkt[`GPIO_PKT_SRCADDR]    = req_dstaddr;
   end

   // Payload registers
   always_ff @(posedge clk) begin
      if (accept) begin
         req_pkt <= packet_in;
      end
      if ((state == gpio_pkg::EXEC) && !req_write) begin
         packet_out <= resp_pkt;   // Frozen until RESP ends
      end
   end

   // ##############################
   // State machine
   // ##############################

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= gpio_pkg::IDLE;
         access_out <= 1'b0;
      end else begin
         case (state)
            gpio_pkg::IDLE: begin
               if (access_in) begin
                  state <= gpio_pkg::EXEC;
               end
            end
            gpio_pkg::EXEC: begin
               if (req_write) begin
                  state <= gpio_pkg::IDLE;  // Writes are silent
               end else begin
                  state      <= gpio_pkg::RESP;
                  access_out <= 1'b1;
               end
            end
            gpio_pkg::RESP: begin
               // Hold everything while the receiver stalls
               if (!wait_in) begin
                  state      <= gpio_pkg::IDLE;
                  access_out <= 1'b0;
               end
            end
            default: begin
               state      <= gpio_pkg::IDLE;
               access_out <= 1'b0;
            end
         endcase
      end
   end

endmodule

// ==== hw/gpio_config.svh ====
`ifndef GPIO_CONFIG_SVH
`define GPIO_CONFIG_SVH

// ##############################
// Widths
// ##############################
`define GPIO_N  32           // Pin count
`define GPIO_AW 32           // Address and data width
`define GPIO_PW 104          // Mesh packet width

// Packet fields, LSB first
`define GPIO_PKT_WRITE    0
`define GPIO_PKT_DATAMODE 2:1
`define GPIO_PKT_CTRLMODE 7:3
`define GPIO_PKT_DSTADDR  39:8
`define GPIO_PKT_DATA     71:40
`define GPIO_PKT_SRCADDR  103:72

// Register index, dstaddr[5:2]
`define GPIO_REG_OUT    4'd0
`define GPIO_REG_OEN    4'd1
`define GPIO_REG_IN     4'd2
`define GPIO_REG_IE     4'd3
`define GPIO_REG_IPOL   4'd4
`define GPIO_REG_ILAT   4'd5
`define GPIO_REG_OUTSET 4'd6
`define GPIO_REG_OUTCLR 4'd7

`define GPIO_DEBOUNCE_CYCLES 4   // Stable cycles before an input is taken

`endif

// ==== hw/gpio_debounce.sv ====
`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_debounce (
   input  logic                    clk,
   input  logic                    reset,
   input  gpio_pkg::pin_vec_t      pins,       // Asynchronous pads
   output gpio_pkg::pin_vec_t      in_stable
);

   localparam int DEB = `GPIO_DEBOUNCE_CYCLES;
   localparam int CW  = $clog2(DEB + 1);

   gpio_pkg::pin_vec_t sync1;
   gpio_pkg::pin_vec_t sync2;
   gpio_pkg::pin_vec_t prev;       // sync2 one cycle back
   logic [CW-1:0]      cnt;        // Cycles without change
   logic               changed;
   logic               settled;

   // ##############################
   // Synchronizer
   // ##############################

   always_ff @(posedge clk) begin
      if (reset) begin
         sync1 <= '0;
         sync2 <= '0;
      end else begin
         sync1 <= pins;
         sync2 <= sync1;
      end
   end

   // ##############################
   // Stability timer
   // ##############################

   assign changed = (sync2 != prev);
   assign settled = !changed && (cnt == CW'(DEB));

   always_ff @(posedge clk) begin
      if (reset) begin
         prev      <= '0;
         cnt       <= '0;
         in_stable <= '0;
      end else begin
         prev <= sync2;
         if (changed) begin
            cnt <= '0;               // Any bit moved, start over
         end else if (cnt != CW'(DEB)) begin
            cnt <= cnt + 1'b1;       // Saturates at DEB
         end
         if (settled) begin
            in_stable <= sync2;      // Whole vector at once
         end
      end
   end

endmodule

// ==== hw/gpio_pkg.sv ====
`include "gpio_config.svh"

package gpio_pkg;

   // ##############################
   // Vector types
   // ##############################

   // One whole mesh packet
   typedef logic [`GPIO_PW-1:0] packet_t;

   // Register contents, also addresses
   typedef logic [`GPIO_AW-1:0] word_t;

   // One bit per pin
   typedef logic [`GPIO_N-1:0]  pin_vec_t;

   // Index into the register bank
   typedef logic [3:0]          reg_addr_t;

   // ##############################
   // Access FSM
   // ##############################

   // IDLE   waiting for a request, wait_out low
   // EXEC   register operation on the bank
   // RESP   read response held until taken
   typedef enum logic [1:0] {
      IDLE,
      EXEC,
      RESP
   } access_state_t;

endpackage

// ==== hw/gpio_regs.sv ====
`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_regs (
   input  logic                    clk,
   input  logic                    reset,
   // Access from the FSM
   input  logic                    reg_wr,
   input  gpio_pkg::reg_addr_t     reg_addr,
   input  gpio_pkg::word_t         reg_wdata,
   output gpio_pkg::word_t         reg_rdata,
   // Pin side
   input  gpio_pkg::pin_vec_t      in_stable,
   output gpio_pkg::pin_vec_t      gpio_out,
   output gpio_pkg::pin_vec_t      gpio_oen,
   output logic                    gpio_irq
);

   gpio_pkg::pin_vec_t out_reg;
   gpio_pkg::pin_vec_t oen_reg;
   gpio_pkg::pin_vec_t ie_reg;
   gpio_pkg::pin_vec_t ipol_reg;
   gpio_pkg::pin_vec_t ilat_reg;
   gpio_pkg::pin_vec_t lvl_q;      // Last active-level vector

   gpio_pkg::pin_vec_t wpins;      // Write data, pin wide
   gpio_pkg::pin_vec_t lvl;        // Input after polarity
   gpio_pkg::pin_vec_t ilat_set;
   gpio_pkg::pin_vec_t ilat_clr;

   assign wpins = reg_wdata[`GPIO_N-1:0];

   // ##############################
   // Interrupt edge detect
   // ##############################

   assign lvl      = in_stable ^ ipol_reg;   // 1 = active level
   assign ilat_set = lvl & ~lvl_q;           // Rising into active
   assign ilat_clr = (reg_wr && (reg_addr == `GPIO_REG_ILAT)) ? wpins : '0;

   always_ff @(posedge clk) begin
      if (reset) begin
         lvl_q    <= '0;
         ilat_reg <= '0;
      end else begin
         lvl_q    <= lvl;
         ilat_reg <= (ilat_reg & ~ilat_clr) | ilat_set;  // Set beats clear
      end
   end

   // ##############################
   // Writable registers
   // ##############################

   always_ff @(posedge clk) begin
      if (reset) begin
         out_reg  <= '0;
         oen_reg  <= '0;
         ie_reg   <= '0;
         ipol_reg <= '0;
      end else if (reg_wr) begin
         case (reg_addr)
            `GPIO_REG_OUT:    out_reg  <= wpins;
            `GPIO_REG_OEN:    oen_reg  <= wpins;
            `GPIO_REG_IE:     ie_reg   <= wpins;
            `GPIO_REG_IPOL:   ipol_reg <= wpins;
            `GPIO_REG_OUTSET: out_reg  <= out_reg | wpins;   // Set ones
            `GPIO_REG_OUTCLR: out_reg  <= out_reg & ~wpins;  // Clear ones
            default: ;   // IN is read-only, ILAT handled above
         endcase
      end
   end

   // ##############################
   // Read mux
   // ##############################

   always_comb begin
      case (reg_addr)
         `GPIO_REG_OUT,
         `GPIO_REG_OUTSET,
         `GPIO_REG_OUTCLR: reg_rdata = gpio_pkg::word_t'(out_reg);
         `GPIO_REG_OEN:    reg_rdata = gpio_pkg::word_t'(oen_reg);
         `GPIO_REG_IN:     reg_rdata = gpio_pkg::word_t'(in_stable);
         `GPIO_REG_IE:     reg_rdata = gpio_pkg::word_t'(ie_reg);
         `GPIO_REG_IPOL:   reg_rdata = gpio_pkg::word_t'(ipol_reg);
         `GPIO_REG_ILAT:   reg_rdata = gpio_pkg::word_t'(ilat_reg);
         default:          reg_rdata = '0;   // Unmapped slots
      endcase
   end

   // Pin drivers
   assign gpio_out = out_reg;
   assign gpio_oen = oen_reg;
   assign gpio_irq = |(ilat_reg & ie_reg);   // Any enabled latch

endmodule

// ==== hw/gpio_top.sv ====
`timescale 1ns/1ps

module gpio_top (
   input  logic                    clk,
   input  logic                    reset,
   // Mesh request port
   input  logic                    access_in,
   input  gpio_pkg::packet_t       packet_in,
   output logic                    wait_out,
   // Mesh response port
   output logic                    access_out,
   output gpio_pkg::packet_t       packet_out,
   input  logic                    wait_in,
   // Pins
   input  gpio_pkg::pin_vec_t      gpio_in,
   output gpio_pkg::pin_vec_t      gpio_out,
   output gpio_pkg::pin_vec_t      gpio_oen,
   output logic                    gpio_irq
);

   // ##############################
   // Internal wiring
   // ##############################

   logic                reg_wr;
   gpio_pkg::reg_addr_t reg_addr;
   gpio_pkg::word_t     reg_wdata;
   gpio_pkg::word_t     reg_rdata;   // Combinational read data
   gpio_pkg::pin_vec_t  in_stable;   // Debounced pins

   // Packet handling and handshake
   gpio_access_fsm u_fsm (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .reg_wr     (reg_wr),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata)
   );

   // Register bank and interrupt
   gpio_regs u_regs (
      .clk        (clk),
      .reset      (reset),
      .reg_wr     (reg_wr),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .in_stable  (in_stable),
      .gpio_out   (gpio_out),
      .gpio_oen   (gpio_oen),
      .gpio_irq   (gpio_irq)
   );

   gpio_debounce u_deb (
      .clk        (clk),
      .reset      (reset),
      .pins       (gpio_in),     // Raw pads in
      .in_stable  (in_stable)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the GPIO testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary -sv --top-module gpio_tb -f files.f --Mdir "$OBJ_DIR" -o gpio_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

"./$OBJ_DIR/gpio_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

# Verdict comes from the log only
if grep -q "^STATUS: PASS$" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi

echo "Simulation failed"
exit 1
